// File: rtl/rvv_cfg_pkg.sv
/*
  Sizes of the vector retire datapath.
  Shared by the RTL and the testbench; modules import it inside their body
  and use scoped names in their port lists.
*/

package rvv_cfg_pkg;

  // retire lanes per cycle, lane 0 holds the oldest entry
  localparam int NUM_RT_UOP = 4;

  // vector register geometry
  localparam int VLEN  = 128;
  localparam int VLENB = VLEN / 8;   // byte lanes per register

  // scalar side
  localparam int XLEN = 32;

  localparam int REG_IDX_W = 5;      // 32 architectural registers

  // body/tail class code per byte, VLENB codes per entry
  localparam int VD_TYPE_W = 2;

  // packed vector CSR state reported on a trap
  localparam int VCSR_W = 32;

endpackage : rvv_cfg_pkg

// File: rtl/rvv_retire_pkg.sv
/*
  Encodings and the result word seen at the retire boundary.
  The result word is read as a full vector for VRF writes and as a
  scalar in its low bits for XRF writes.
*/

package rvv_retire_pkg;

  //////////////////////////////////////////////////////////////
  // byte class and target encodings
  //////////////////////////////////////////////////////////////

  // byte class that is actually written back
  localparam logic [rvv_cfg_pkg::VD_TYPE_W-1:0] VD_BODY_ACTIVE = 2'd3;

  localparam logic W_TYPE_VRF = 1'b0;   // vector register file
  localparam logic W_TYPE_XRF = 1'b1;   // scalar register file

  //////////////////////////////////////////////////////////////
  // result word
  //////////////////////////////////////////////////////////////

  // scalar result sits in the low XLEN bits, upper bits are don't care
  typedef struct packed {
    logic [rvv_cfg_pkg::VLEN-rvv_cfg_pkg::XLEN-1:0] pad;
    logic [rvv_cfg_pkg::XLEN-1:0]                   data;
  } rt_scalar_s;

  typedef union packed {
    logic [rvv_cfg_pkg::VLEN-1:0] vec;      // full vector view
    rt_scalar_s                   scalar;   // XRF view
  } rt_result_u;

endpackage : rvv_retire_pkg

// File: rtl/rt_trap_scan.sv
/*
  Trap scan over one retire group.
  Kills every lane younger than a trapping entry and forwards the vector
  CSR state of the oldest trapping entry that has a write.
*/

`timescale 1ns/10ps

module rt_trap_scan (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                   rob_w_valid,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                   rob_trap,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0][rvv_cfg_pkg::VCSR_W-1:0] rob_vcsr,
  output logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                   lane_kill,
  output logic                                                 vcsr_wr_valid,
  output logic [rvv_cfg_pkg::VCSR_W-1:0]                       vcsr_wr_data
);

  import rvv_cfg_pkg::*;

  // kill chain, a trap on lane i kills lanes i+1 and up
  always_comb begin
    lane_kill[0] = 1'b0;   // oldest entry always retires
    for (int i = 1; i < NUM_RT_UOP; i++) begin
      lane_kill[i] = lane_kill[i-1] | rob_trap[i-1];
    end
  end

  // priority select, walk from youngest down so the oldest hit wins
  always_comb begin
    vcsr_wr_valid = 1'b0;
    vcsr_wr_data  = '0;
    for (int i = NUM_RT_UOP - 1; i >= 0; i--) begin
      if (rob_w_valid[i] && rob_trap[i]) begin
        vcsr_wr_valid = 1'b1;
        vcsr_wr_data  = rob_vcsr[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////

  // the oldest entry has nothing ahead of it that could trap
  a_lane0_alive: assert property (@(posedge clk) disable iff (!rst_n)
    !lane_kill[0])
    else $error("rt_trap_scan: lane 0 killed");

endmodule : rt_trap_scan

// File: rtl/rt_lane.sv
/*
  One retire lane.
  Decodes the write target of a single ROB entry, builds its byte strobe
  from the body/tail class codes and returns ready to the ROB.
*/

`timescale 1ns/10ps

module rt_lane (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                w_valid,
  input  logic                                                w_type,
  input  logic [rvv_cfg_pkg::VLENB-1:0][rvv_cfg_pkg::VD_TYPE_W-1:0] vd_type,
  input  logic                                                ignore_vta,
  input  logic                                                kill,
  input  logic                                                xrf_ready,
  output logic                                                vrf_valid,
  output logic                                                xrf_valid,
  output logic [rvv_cfg_pkg::VLENB-1:0]                       strobe,
  output logic                                                rob_ready
);

  import rvv_cfg_pkg::*;
  import rvv_retire_pkg::*;

  logic [VLENB-1:0] body_strobe;   // bytes in the active body
  logic             live;          // write survives the trap scan

  //////////////////////////////////////////////////////////////
  // byte strobe
  //////////////////////////////////////////////////////////////

  always_comb begin
    for (int b = 0; b < VLENB; b++) begin
      body_strobe[b] = (vd_type[b] == VD_BODY_ACTIVE);
    end
  end

  // tail agnostic and ignored, whole register goes back
  assign strobe = ignore_vta ? {VLENB{1'b1}} : body_strobe;

  //////////////////////////////////////////////////////////////
  // write target
  //////////////////////////////////////////////////////////////

  assign live = w_valid & ~kill;

  assign vrf_valid = live & (w_type == W_TYPE_VRF);
  assign xrf_valid = live & (w_type == W_TYPE_XRF);

  // only the XRF port can push back, the VRF port takes every write
  assign rob_ready = xrf_valid ? xrf_ready : 1'b1;

  //////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////

  a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
    !(vrf_valid && xrf_valid))
    else $error("rt_lane: VRF and XRF write in the same lane");

endmodule : rt_lane

// File: rtl/rt_waw_merge.sv
/*
  Write-after-write merge across one retire group.
  Consecutive entries from entry 0 with the same valid and target form a
  group; inside it each byte of a register is kept only in the youngest
  entry that writes it.
*/

`timescale 1ns/10ps

module rt_waw_merge (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                rob_valid,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                rob_w_type,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0][rvv_cfg_pkg::REG_IDX_W-1:0] rob_w_index,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0][rvv_cfg_pkg::VLENB-1:0]     lane_strobe,
  output logic [rvv_cfg_pkg::NUM_RT_UOP-1:0][rvv_cfg_pkg::VLENB-1:0]     vrf_wr_strobe
);

  import rvv_cfg_pkg::*;
  import rvv_retire_pkg::*;

  logic [NUM_RT_UOP-1:0]            in_grp;    // entry belongs to the leading group
  logic [NUM_RT_UOP-1:0][VLENB-1:0] waw_hit;   // bytes rewritten by a younger entry

  //////////////////////////////////////////////////////////////
  // group detect
  //////////////////////////////////////////////////////////////

  // run of equal (valid, type) pairs starting at the oldest entry
  always_comb begin
    in_grp[0] = 1'b1;
    for (int i = 1; i < NUM_RT_UOP; i++) begin
      in_grp[i] = in_grp[i-1] &
                  ({rob_valid[i], rob_w_type[i]} == {rob_valid[i-1], rob_w_type[i-1]});
    end
  end

  //////////////////////////////////////////////////////////////
  // byte clear
  //////////////////////////////////////////////////////////////

  // an entry outside the group has no grouped entry behind it,
  // so its hit vector stays zero and the strobe passes through
  always_comb begin
    for (int i = 0; i < NUM_RT_UOP; i++) begin
      waw_hit[i] = '0;
      for (int j = i + 1; j < NUM_RT_UOP; j++) begin
        if (in_grp[j] && (rob_w_index[j] == rob_w_index[i])) begin
          waw_hit[i] = waw_hit[i] | lane_strobe[j];   // younger writer owns the byte
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_RT_UOP; i++) begin
      vrf_wr_strobe[i] = lane_strobe[i] & ~waw_hit[i];
    end
  end

  //////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////

  // in_grp is a prefix, so in_grp[j] also covers every older i
  for (genvar i = 0; i < NUM_RT_UOP - 1; i++) begin : g_chk_old
    for (genvar j = i + 1; j < NUM_RT_UOP; j++) begin : g_chk_young
      a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        (in_grp[j] && (rob_w_index[i] == rob_w_index[j]) && (rob_w_type[j] == W_TYPE_VRF))
          |-> ((vrf_wr_strobe[i] & vrf_wr_strobe[j]) == '0))
        else $error("rt_waw_merge: byte %0d/%0d written twice", i, j);
    end
  end

endmodule : rt_waw_merge

// File: rtl/rvv_retire.sv
/*
  Vector retire stage, fully combinational.
  Takes up to four retiring ROB entries, entry 0 oldest, and writes them
  to the VRF and XRF ports; a trap kills younger entries and reports its
  vector CSR state. clk and rst_n only serve the assertions.
*/

`timescale 1ns/10ps

module rvv_retire (
  input  logic clk,
  input  logic rst_n,

  // from the ROB, one entry per lane
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                        rob_valid,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                        rob_w_valid,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                        rob_w_type,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0][rvv_cfg_pkg::REG_IDX_W-1:0] rob_w_index,
  input  rvv_retire_pkg::rt_result_u [rvv_cfg_pkg::NUM_RT_UOP-1:0]  rob_w_data,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0][rvv_cfg_pkg::VLENB-1:0]
               [rvv_cfg_pkg::VD_TYPE_W-1:0]                         rob_vd_type,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                        rob_ignore_vta,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                        rob_trap,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0][rvv_cfg_pkg::VCSR_W-1:0] rob_vcsr,
  output logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                        rob_ready,

  // VRF write ports
  output logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                        vrf_wr_valid,
  output logic [rvv_cfg_pkg::NUM_RT_UOP-1:0][rvv_cfg_pkg::REG_IDX_W-1:0] vrf_wr_index,
  output logic [rvv_cfg_pkg::NUM_RT_UOP-1:0][rvv_cfg_pkg::VLEN-1:0] vrf_wr_data,
  output logic [rvv_cfg_pkg::NUM_RT_UOP-1:0][rvv_cfg_pkg::VLENB-1:0] vrf_wr_strobe,

  // XRF write ports
  output logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                        xrf_wr_valid,
  output logic [rvv_cfg_pkg::NUM_RT_UOP-1:0][rvv_cfg_pkg::REG_IDX_W-1:0] xrf_wr_index,
  output logic [rvv_cfg_pkg::NUM_RT_UOP-1:0][rvv_cfg_pkg::XLEN-1:0] xrf_wr_data,
  input  logic [rvv_cfg_pkg::NUM_RT_UOP-1:0]                        xrf_ready,

  // vector CSR update on trap
  output logic                                                      vcsr_wr_valid,
  output logic [rvv_cfg_pkg::VCSR_W-1:0]                            vcsr_wr_data
);

  import rvv_cfg_pkg::*;
  import rvv_retire_pkg::*;

  logic [NUM_RT_UOP-1:0]            lane_kill;
  logic [NUM_RT_UOP-1:0][VLENB-1:0] lane_strobe;   // before WAW clearing

  //////////////////////////////////////////////////////////////
  // trap scan
  //////////////////////////////////////////////////////////////

  rt_trap_scan i_trap_scan (
    .clk           (clk),
    .rst_n         (rst_n),
    .rob_w_valid   (rob_w_valid),
    .rob_trap      (rob_trap),
    .rob_vcsr      (rob_vcsr),
    .lane_kill     (lane_kill),
    .vcsr_wr_valid (vcsr_wr_valid),
    .vcsr_wr_data  (vcsr_wr_data)
  );

  //////////////////////////////////////////////////////////////
  // lanes
  //////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_RT_UOP; i++) begin : g_lane
    rt_lane i_lane (
      .clk        (clk),
      .rst_n      (rst_n),
      .w_valid    (rob_w_valid[i]),
      .w_type     (rob_w_type[i]),
      .vd_type    (rob_vd_type[i]),
      .ignore_vta (rob_ignore_vta[i]),
      .kill       (lane_kill[i]),
      .xrf_ready  (xrf_ready[i]),
      .vrf_valid  (vrf_wr_valid[i]),
      .xrf_valid  (xrf_wr_valid[i]),
      .strobe     (lane_strobe[i]),
      .rob_ready  (rob_ready[i])
    );

    // both ports see the same index, data by its own view
    assign vrf_wr_index[i] = rob_w_index[i];
    assign xrf_wr_index[i] = rob_w_index[i];
    assign vrf_wr_data[i]  = rob_w_data[i].vec;
    assign xrf_wr_data[i]  = rob_w_data[i].scalar.data;

    // nothing writes behind a trapping entry
    a_trap_stops_writes: assert property (@(posedge clk) disable iff (!rst_n)
      rob_trap[i] |-> (((vrf_wr_valid | xrf_wr_valid) >> (i + 1)) == '0))
      else $error("rvv_retire: write behind trap on lane %0d", i);

    // a VRF entry with no older trap never stalls the ROB
    a_vrf_ready: assert property (@(posedge clk) disable iff (!rst_n)
      (rob_w_valid[i] && (rob_w_type[i] == W_TYPE_VRF)) |-> rob_ready[i])
      else $error("rvv_retire: VRF lane %0d not ready", i);
  end

  //////////////////////////////////////////////////////////////
  // WAW merge
  //////////////////////////////////////////////////////////////

  rt_waw_merge i_waw_merge (
    .clk           (clk),
    .rst_n         (rst_n),
    .rob_valid     (rob_valid),
    .rob_w_type    (rob_w_type),
    .rob_w_index   (rob_w_index),
    .lane_strobe   (lane_strobe),
    .vrf_wr_strobe (vrf_wr_strobe)
  );

endmodule : rvv_retire

// File: verif/tb_rvv_retire.sv
/*
  Testbench for the vector retire stage.
  Drives groups of four ROB entries on the falling clock edge and compares
  every output against a reference model of the retire rules.
*/

`timescale 1ns/10ps

module tb_rvv_retire;

  import rvv_cfg_pkg::*;
  import rvv_retire_pkg::*;

  localparam int          CLK_PERIOD    = 40;
  localparam int          RESET_CYCLES  = 16;
  localparam int          READY_TIMEOUT = 10;        // cycles
  localparam int          NUM_RANDOM    = 200;
  localparam logic [15:0] LFSR_SEED     = 16'd5909;
  localparam logic [15:0] LFSR_TAPS     = 16'hb400;  // x^16 + x^14 + x^13 + x^11 + 1

  logic clk;
  logic rst_n;

  logic [NUM_RT_UOP-1:0]                            rob_valid, rob_w_valid, rob_w_type;
  logic [NUM_RT_UOP-1:0][REG_IDX_W-1:0]             rob_w_index;
  rt_result_u [NUM_RT_UOP-1:0]                      rob_w_data;
  logic [NUM_RT_UOP-1:0][VLENB-1:0][VD_TYPE_W-1:0]  rob_vd_type;
  logic [NUM_RT_UOP-1:0]                            rob_ignore_vta, rob_trap, rob_ready;
  logic [NUM_RT_UOP-1:0][VCSR_W-1:0]                rob_vcsr;
  logic [NUM_RT_UOP-1:0]                            vrf_wr_valid, xrf_wr_valid, xrf_ready;
  logic [NUM_RT_UOP-1:0][REG_IDX_W-1:0]             vrf_wr_index, xrf_wr_index;
  logic [NUM_RT_UOP-1:0][VLEN-1:0]                  vrf_wr_data;
  logic [NUM_RT_UOP-1:0][VLENB-1:0]                 vrf_wr_strobe;
  logic [NUM_RT_UOP-1:0][XLEN-1:0]                  xrf_wr_data;
  logic                                             vcsr_wr_valid;
  logic [VCSR_W-1:0]                                vcsr_wr_data;

  int          errors = 0;
  int          checks = 0;
  logic [15:0] lfsr_state = LFSR_SEED;

  rvv_retire i_rvv_retire (
    .clk            (clk),
    .rst_n          (rst_n),
    .rob_valid      (rob_valid),
    .rob_w_valid    (rob_w_valid),
    .rob_w_type     (rob_w_type),
    .rob_w_index    (rob_w_index),
    .rob_w_data     (rob_w_data),
    .rob_vd_type    (rob_vd_type),
    .rob_ignore_vta (rob_ignore_vta),
    .rob_trap       (rob_trap),
    .rob_vcsr       (rob_vcsr),
    .rob_ready      (rob_ready),
    .vrf_wr_valid   (vrf_wr_valid),
    .vrf_wr_index   (vrf_wr_index),
    .vrf_wr_data    (vrf_wr_data),
    .vrf_wr_strobe  (vrf_wr_strobe),
    .xrf_wr_valid   (xrf_wr_valid),
    .xrf_wr_index   (xrf_wr_index),
    .xrf_wr_data    (xrf_wr_data),
    .xrf_ready      (xrf_ready),
    .vcsr_wr_valid  (vcsr_wr_valid),
    .vcsr_wr_data   (vcsr_wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic clear_inputs();
    rob_valid      = '0;
    rob_w_valid    = '0;
    rob_w_type     = '0;
    rob_w_index    = '0;
    rob_w_data     = '0;
    rob_vd_type    = '0;
    rob_ignore_vta = '0;
    rob_trap       = '0;
    rob_vcsr       = '0;
    xrf_ready      = '1;   // register file idle
  endtask

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [VLEN-1:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v[k]       = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_strobe(string name, logic [VLENB-1:0] exp, logic [VLENB-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // scalar_view compares only the XRF part of the word
  task automatic check_word(string name, rt_result_u exp, rt_result_u act, bit scalar_view);
    checks++;
    if (scalar_view ? (act.scalar.data !== exp.scalar.data) : (act.vec !== exp.vec)) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name,
               scalar_view ? VLEN'(exp.scalar.data) : exp.vec,
               scalar_view ? VLEN'(act.scalar.data) : act.vec);
    end
  endtask

  task automatic check_index(string name, logic [REG_IDX_W-1:0] exp, logic [REG_IDX_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_csr(string name, logic [VCSR_W-1:0] exp, logic [VCSR_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model, checks every output of the group
  ////////////////////////////////////////////////////////////

  task automatic check_all();
    logic [NUM_RT_UOP-1:0][VLENB-1:0] body;
    logic [VLENB-1:0]                 exp_strb;
    logic [NUM_RT_UOP-1:0]            dead;
    logic                             exp_vrf, exp_xrf, csr_v, trap_seen;
    logic [VCSR_W-1:0]                csr_d;
    rt_result_u                       act;
    int                               grp_len;
    csr_v     = 1'b0;
    csr_d     = '0;
    trap_seen = 1'b0;
    grp_len   = 1;
    for (int i = 0; i < NUM_RT_UOP; i++) begin
      for (int b = 0; b < VLENB; b++) begin
        body[i][b] = rob_ignore_vta[i] || (rob_vd_type[i][b] == VD_BODY_ACTIVE);
      end
      dead[i] = trap_seen;                 // any older trap kills this entry
      trap_seen = trap_seen | rob_trap[i];
      if (!csr_v && rob_w_valid[i] && rob_trap[i]) begin
        csr_v = 1'b1;
        csr_d = rob_vcsr[i];
      end
    end
    while (grp_len < NUM_RT_UOP && rob_valid[grp_len] == rob_valid[grp_len-1] &&
           rob_w_type[grp_len] == rob_w_type[grp_len-1]) begin
      grp_len++;
    end
    for (int i = 0; i < NUM_RT_UOP; i++) begin
      exp_strb = body[i];
      for (int j = i + 1; j < grp_len; j++) begin
        if (rob_w_index[j] == rob_w_index[i]) exp_strb = exp_strb & ~body[j];
      end
      exp_vrf = rob_w_valid[i] && !dead[i] && (rob_w_type[i] == W_TYPE_VRF);
      exp_xrf = rob_w_valid[i] && !dead[i] && (rob_w_type[i] == W_TYPE_XRF);
      check_bit($sformatf("vrf_wr_valid[%0d]", i), exp_vrf, vrf_wr_valid[i]);
      check_bit($sformatf("xrf_wr_valid[%0d]", i), exp_xrf, xrf_wr_valid[i]);
      check_bit($sformatf("rob_ready[%0d]", i), exp_xrf ? xrf_ready[i] : 1'b1, rob_ready[i]);
      check_strobe($sformatf("vrf_wr_strobe[%0d]", i), exp_strb, vrf_wr_strobe[i]);
      check_index($sformatf("vrf_wr_index[%0d]", i), rob_w_index[i], vrf_wr_index[i]);
      check_index($sformatf("xrf_wr_index[%0d]", i), rob_w_index[i], xrf_wr_index[i]);
      act.vec = vrf_wr_data[i];
      check_word($sformatf("vrf_wr_data[%0d]", i), rob_w_data[i], act, 1'b0);
      act             = '0;
      act.scalar.data = xrf_wr_data[i];
      check_word($sformatf("xrf_wr_data[%0d]", i), rob_w_data[i], act, 1'b1);
    end
    check_bit("vcsr_wr_valid", csr_v, vcsr_wr_valid);
    check_csr("vcsr_wr_data", csr_d, vcsr_wr_data);
  endtask

  // waits for the ROB handshake on one lane
  task automatic wait_ready(int lane);
    int n;
    n = 0;
    #(CLK_PERIOD / 4);
    while (rob_ready[lane] !== 1'b1 && n < READY_TIMEOUT) begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      n++;
    end
    if (rob_ready[lane] !== 1'b1) begin
      errors++;
      $display("timeout: rob_ready on lane %0d stayed low for %0d cycles", lane, n);
    end
  endtask

  task automatic end_test(string name, int err0);
    $display("test %-14s %s (%0d errors)", name, (errors == err0) ? "ok" : "FAILED",
             errors - err0);
  endtask

  // all lanes valid VRF writes, index i+1
  task automatic load_vrf_group();
    clear_inputs();
    rob_valid   = '1;
    rob_w_valid = '1;
    rob_w_type  = {NUM_RT_UOP{W_TYPE_VRF}};
    for (int i = 0; i < NUM_RT_UOP; i++) rob_w_index[i] = REG_IDX_W'(i + 1);
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_strobe_decode();
    int err0;
    err0 = errors;
    @(negedge clk);
    load_vrf_group();
    rob_vd_type[0] = '1;                  // every byte active
    rob_vd_type[2] = {8{2'd1, 2'd3}};     // even bytes active
    rob_vd_type[3] = 32'h0000_ffff;       // low half active
    #(CLK_PERIOD / 4);
    check_strobe("vrf_wr_strobe[0]", 16'hffff, vrf_wr_strobe[0]);
    check_strobe("vrf_wr_strobe[1]", 16'h0000, vrf_wr_strobe[1]);
    check_strobe("vrf_wr_strobe[2]", 16'h5555, vrf_wr_strobe[2]);
    check_strobe("vrf_wr_strobe[3]", 16'h00ff, vrf_wr_strobe[3]);
    check_all();
    @(negedge clk);
    rob_ignore_vta = '1;
    #(CLK_PERIOD / 4);
    for (int i = 0; i < NUM_RT_UOP; i++) begin
      check_strobe($sformatf("vrf_wr_strobe[%0d]", i), 16'hffff, vrf_wr_strobe[i]);
    end
    check_all();
    end_test("strobe_decode", err0);
  endtask

  task automatic test_waw();
    int err0;
    err0 = errors;
    @(negedge clk);
    load_vrf_group();
    rob_w_index    = {NUM_RT_UOP{5'd5}};
    rob_vd_type[0] = '1;
    rob_vd_type[1] = 32'h0000_ffff;       // bytes 7..0
    rob_vd_type[2] = 32'h00ff_0000;       // bytes 11..8
    rob_vd_type[3] = 32'h0000_000f;       // bytes 1..0
    #(CLK_PERIOD / 4);
    check_strobe("vrf_wr_strobe[0]", 16'hf000, vrf_wr_strobe[0]);
    check_strobe("vrf_wr_strobe[1]", 16'h00fc, vrf_wr_strobe[1]);
    check_strobe("vrf_wr_strobe[2]", 16'h0f00, vrf_wr_strobe[2]);
    check_strobe("vrf_wr_strobe[3]", 16'h0003, vrf_wr_strobe[3]);
    check_all();
    @(negedge clk);
    rob_vd_type = '1;
    rob_w_index = {5'd6, 5'd5, 5'd6, 5'd5};   // lane 0 first from the right
    #(CLK_PERIOD / 4);
    check_strobe("vrf_wr_strobe[0]", 16'h0000, vrf_wr_strobe[0]);
    check_strobe("vrf_wr_strobe[1]", 16'h0000, vrf_wr_strobe[1]);
    check_all();
    @(negedge clk);
    rob_w_type[2] = W_TYPE_XRF;           // group ends after lane 1
    #(CLK_PERIOD / 4);
    check_strobe("vrf_wr_strobe[0]", 16'hffff, vrf_wr_strobe[0]);
    check_strobe("vrf_wr_strobe[1]", 16'hffff, vrf_wr_strobe[1]);
    check_all();
    end_test("waw", err0);
  endtask

  task automatic test_trap();
    int err0;
    err0 = errors;
    @(negedge clk);
    load_vrf_group();
    rob_vd_type = '1;
    for (int i = 0; i < NUM_RT_UOP; i++) rob_vcsr[i] = 32'h5a00_0000 | VCSR_W'(i);
    rob_trap[1] = 1'b1;
    #(CLK_PERIOD / 4);
    check_bit("vrf_wr_valid[0]", 1'b1, vrf_wr_valid[0]);
    check_bit("vrf_wr_valid[1]", 1'b1, vrf_wr_valid[1]);
    check_bit("vrf_wr_valid[2]", 1'b0, vrf_wr_valid[2]);
    check_bit("vrf_wr_valid[3]", 1'b0, vrf_wr_valid[3]);
    check_bit("vcsr_wr_valid", 1'b1, vcsr_wr_valid);
    check_csr("vcsr_wr_data", 32'h5a00_0001, vcsr_wr_data);
    check_all();
    @(negedge clk);
    rob_trap = '0;
    #(CLK_PERIOD / 4);
    check_bit("vcsr_wr_valid", 1'b0, vcsr_wr_valid);
    check_all();
    end_test("trap", err0);
  endtask

  task automatic test_xrf();
    rt_result_u exp_w, act;
    int         err0;
    err0 = errors;
    @(negedge clk);
    load_vrf_group();
    rob_w_type    = 4'b0101;              // lanes 0 and 2 go to the XRF
    rob_w_data[0] = 128'h0f1e2d3c_4b5a6978_01234567_89abcdef;
    rob_w_data[2] = 128'h11111111_22222222_33333333_cafe0042;
    xrf_ready     = 4'b0001;              // busy on VRF lanes 1 and 3 as well
    #(CLK_PERIOD / 4);
    exp_w             = '0;
    exp_w.scalar.data = 32'h89ab_cdef;
    act               = '0;
    act.scalar.data   = xrf_wr_data[0];
    check_word("xrf_wr_data[0]", exp_w, act, 1'b1);
    check_bit("rob_ready[0]", 1'b1, rob_ready[0]);
    check_bit("rob_ready[1]", 1'b1, rob_ready[1]);
    check_bit("rob_ready[2]", 1'b0, rob_ready[2]);
    check_bit("rob_ready[3]", 1'b1, rob_ready[3]);
    check_all();
    @(negedge clk);
    xrf_ready[2] = 1'b1;                  // XRF frees up
    wait_ready(2);
    check_all();
    end_test("xrf_ready", err0);
  endtask

  task automatic test_random();
    logic [VLEN-1:0] r;
    int              err0;
    err0 = errors;
    for (int g = 0; g < NUM_RANDOM; g++) begin
      @(negedge clk);
      for (int i = 0; i < NUM_RT_UOP; i++) begin
        rand_bits(2, r);
        rob_valid[i] = |r[1:0];
        rand_bits(1, r);
        rob_w_valid[i] = rob_valid[i] & r[0];
        rand_bits(2, r);
        rob_w_type[i] = &r[1:0];          // mostly VRF
        rand_bits(2, r);
        rob_w_index[i] = REG_IDX_W'(r[1:0]);   // few indexes, many WAW hits
        rand_bits(VLEN, r);
        rob_w_data[i] = r;
        rand_bits(VLENB * VD_TYPE_W, r);
        rob_vd_type[i] = r[VLENB*VD_TYPE_W-1:0];
        rand_bits(2, r);
        rob_ignore_vta[i] = &r[1:0];
        rand_bits(3, r);
        rob_trap[i] = &r[2:0];
        rand_bits(VCSR_W, r);
        rob_vcsr[i] = r[VCSR_W-1:0];
        rand_bits(1, r);
        xrf_ready[i] = r[0];
      end
      #(CLK_PERIOD / 4);
      check_all();
    end
    end_test("random", err0);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    clear_inputs();
    for (int c = 0; c < RESET_CYCLES; c++) @(posedge clk);
    #(CLK_PERIOD / 4);
    check_all();                          // idle outputs while in reset
    @(negedge clk);
    rst_n = 1'b1;
    test_strobe_decode();
    test_waw();
    test_trap();
    test_xrf();
    test_random();
    $display("done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : tb_rvv_retire

// File: vlog.f
rtl/rvv_cfg_pkg.sv
rtl/rvv_retire_pkg.sv
rtl/rt_trap_scan.sv
rtl/rt_lane.sv
rtl/rt_waw_merge.sv
rtl/rvv_retire.sv
verif/tb_rvv_retire.sv

// File: run_sim.sh
#!/bin/sh
# builds the retire stage testbench with Verilator and runs it
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_rvv_retire -f vlog.f -Mdir obj_dir -o sim_tb \
  > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1

cat build.log sim.log 2> /dev/null

grep -qx "Verification passed" sim.log \
  && echo "run_sim: PASS" \
  || { echo "run_sim: FAIL"; exit 1; }
